//--- source/rv32_csr_addr_pkg.sv
package rv32_csr_addr_pkg;

    // Machine information and trap setup
    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_misa      = 12'h301;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    localparam logic [11:0] csr_mscratch  = 12'h340;
    localparam logic [11:0] csr_mepc      = 12'h341;

    // Machine counters
    localparam logic [11:0] csr_mcycle    = 12'hB00;
    localparam logic [11:0] csr_minstret  = 12'hB02;
    localparam logic [11:0] csr_mcycleh   = 12'hB80;
    localparam logic [11:0] csr_minstreth = 12'hB82;

    // User read-only counter shadows
    localparam logic [11:0] csr_cycle     = 12'hC00;
    localparam logic [11:0] csr_time      = 12'hC01;
    localparam logic [11:0] csr_instret   = 12'hC02;
    localparam logic [11:0] csr_cycleh    = 12'hC80;
    localparam logic [11:0] csr_timeh     = 12'hC81;
    localparam logic [11:0] csr_instreth  = 12'hC82;

    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;
    localparam logic [11:0] csr_mimpid    = 12'hF13;
    localparam logic [11:0] csr_mhartid   = 12'hF14;

    // Ranges that read as zero
    localparam logic [11:0] csr_mhpmevent_first    = 12'h323;
    localparam logic [11:0] csr_mhpmevent_last     = 12'h33F;
    localparam logic [11:0] csr_pmpcfg_first       = 12'h3A0;
    localparam logic [11:0] csr_pmpcfg_last        = 12'h3A3;
    localparam logic [11:0] csr_pmpaddr_first      = 12'h3B0;
    localparam logic [11:0] csr_pmpaddr_last       = 12'h3BF;
    localparam logic [11:0] csr_mhpmcounter_first  = 12'hB03;
    localparam logic [11:0] csr_mhpmcounter_last   = 12'hB1F;
    localparam logic [11:0] csr_mhpmcounterh_first = 12'hB83;
    localparam logic [11:0] csr_mhpmcounterh_last  = 12'hB9F;

    // MXL = 1 (32 bit), extension I only
    localparam logic [31:0] misa_value = 32'h4000_0100;

    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic [1:0] access;   // 11 is read-only
            logic [1:0] priv;
            logic [7:0] index;
        } fields;
    } csr_addr_t;

endpackage

//--- source/rv32_csr_op_pkg.sv
package rv32_csr_op_pkg;

    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [2:0] funct3_csrrw  = 3'b001;
    localparam logic [2:0] funct3_csrrs  = 3'b010;
    localparam logic [2:0] funct3_csrrc  = 3'b011;
    localparam logic [2:0] funct3_csrrwi = 3'b101;
    localparam logic [2:0] funct3_csrrsi = 3'b110;
    localparam logic [2:0] funct3_csrrci = 3'b111;

    // I-type layout of a SYSTEM instruction
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_instr_t;

    typedef enum logic [1:0] {
        op_rw = 2'b00,
        op_rs = 2'b01,
        op_rc = 2'b10
    } csr_write_op_t;

    typedef struct packed {
        logic                            valid;
        logic                            read;
        logic                            write;
        csr_write_op_t                   op;
        rv32_csr_addr_pkg::csr_addr_t    addr;
        logic [31:0]                     operand;
    } csr_req_t;

    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] instret;
    } counters_t;

endpackage

//--- source/rv32_csr_decode.sv
`timescale 1ns/1ps

module rv32_csr_decode (
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [31:0]                 rs1_value,
    output rv32_csr_op_pkg::csr_req_t   req
);
    import rv32_csr_op_pkg::*;

    csr_instr_t    fields;
    logic          form_ok;
    logic          use_imm;
    csr_write_op_t op;

    assign fields = csr_instr_t'(instr);

    always_comb begin
        form_ok = 1'b1;
        use_imm = fields.funct3[2];
        case (fields.funct3)
            funct3_csrrw, funct3_csrrwi: op = op_rw;
            funct3_csrrs, funct3_csrrsi: op = op_rs;
            funct3_csrrc, funct3_csrrci: op = op_rc;
            default: begin
                op      = op_rw;
                form_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        req.valid   = instr_valid && (fields.opcode == opcode_system) && form_ok;
        req.op      = op;
        req.addr    = fields.csr;
        req.operand = use_imm ? {27'b0, fields.rs1} : rs1_value;
        // Set and clear with a zero source only read
        req.write   = (op == op_rw) || (fields.rs1 != 5'd0);
        // A swap into x0 skips the read side effect
        req.read    = !((op == op_rw) && (fields.rd == 5'd0));
    end

endmodule

//--- source/rv32_csr_counters.sv
`timescale 1ns/1ps

module rv32_csr_counters (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_retired,
    output rv32_csr_op_pkg::counters_t  counts
);
    import rv32_csr_op_pkg::*;

    logic [63:0] cycle;
    logic [63:0] instret;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // Retire pulses are counted even while the pipeline stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= 64'd0;
        end else if (instr_retired) begin
            instret <= instret + 64'd1;
        end
    end

    always_comb begin
        counts.cycle   = cycle;
        counts.instret = instret;
    end

endmodule

//--- source/rv32_csr_file.sv
`timescale 1ns/1ps

module rv32_csr_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  rv32_csr_op_pkg::csr_req_t   req,
    input  rv32_csr_op_pkg::counters_t  counts,
    output logic [31:0]                 read_value,
    output logic                        illegal
);
    import rv32_csr_addr_pkg::*;
    import rv32_csr_op_pkg::*;

    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic [31:2] mtvec_base;
    logic        mtvec_mode;
    logic [31:0] mscratch;
    logic [31:2] mepc;

    logic [11:0] addr;
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        known;
    logic        write_en;

    assign addr = req.addr.raw;

    always_comb begin
        known = 1'b1;
        case (addr)
            csr_mstatus:   old_value = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
            csr_misa:      old_value = misa_value;
            csr_mtvec:     old_value = {mtvec_base, 1'b0, mtvec_mode};
            csr_mscratch:  old_value = mscratch;
            csr_mepc:      old_value = {mepc, 2'b0};
            csr_mcycle,
            csr_cycle,
            csr_time:      old_value = counts.cycle[31:0];
            csr_mcycleh,
            csr_cycleh,
            csr_timeh:     old_value = counts.cycle[63:32];
            csr_minstret,
            csr_instret:   old_value = counts.instret[31:0];
            csr_minstreth,
            csr_instreth:  old_value = counts.instret[63:32];
            csr_mvendorid,
            csr_marchid,
            csr_mimpid,
            csr_mhartid:   old_value = 32'd0;
            default: begin
                old_value = 32'd0;
                // Hard-wired blocks are matched by range
                known = (addr >= csr_mhpmevent_first    && addr <= csr_mhpmevent_last)
                     || (addr >= csr_pmpcfg_first       && addr <= csr_pmpcfg_last)
                     || (addr >= csr_pmpaddr_first      && addr <= csr_pmpaddr_last)
                     || (addr >= csr_mhpmcounter_first  && addr <= csr_mhpmcounter_last)
                     || (addr >= csr_mhpmcounterh_first && addr <= csr_mhpmcounterh_last);
            end
        endcase
    end

    always_comb begin
        case (req.op)
            op_rw:   new_value = req.operand;
            op_rs:   new_value = old_value | req.operand;
            op_rc:   new_value = old_value & ~req.operand;
            default: new_value = old_value;
        endcase
    end

    assign illegal    = req.valid && (!known || (req.write && req.addr.fields.access == 2'b11));
    assign read_value = (req.valid && known) ? old_value : 32'd0;
    assign write_en   = req.valid && req.write && !stall && !illegal;

    // Only the implemented bits are stored; the rest read back as constants
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mtvec_base   <= 30'd0;
            mtvec_mode   <= 1'b0;
            mscratch     <= 32'd0;
            mepc         <= 30'd0;
        end else if (write_en) begin
            case (addr)
                csr_mstatus: begin
                    mstatus_mpie <= new_value[7];
                    mstatus_mie  <= new_value[3];
                end
                csr_mtvec: begin
                    mtvec_base <= new_value[31:2];
                    mtvec_mode <= new_value[0];
                end
                csr_mscratch: mscratch <= new_value;
                csr_mepc:     mepc     <= new_value[31:2];
                default: ;
            endcase
        end
    end

endmodule

//--- source/rv32_csr_unit.sv
`timescale 1ns/1ps

module rv32_csr_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_value,
    input  logic        instr_retired,
    output logic [31:0] read_value,
    output logic        illegal
);
    import rv32_csr_op_pkg::*;

    csr_req_t  req;
    counters_t counts;

    rv32_csr_decode decode_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .req         (req)
    );

    rv32_csr_counters counters_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_retired (instr_retired),
        .counts        (counts)
    );

    rv32_csr_file file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .req        (req),
        .counts     (counts),
        .read_value (read_value),
        .illegal    (illegal)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

//--- verif/rv32_csr_unit_assert.sv
`timescale 1ns/1ps

module rv32_csr_unit_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      stall,
    input logic                      illegal,
    input rv32_csr_op_pkg::csr_req_t req,
    input logic [31:0]               read_value,
    input logic [94:0]               state
);
    import rv32_csr_addr_pkg::*;

    int fail_count = 0;

    // Stored bits hold across an edge with a blocked write
    assert property (@(posedge clk) disable iff (!rst_n)
        (stall || illegal) |=> $stable(state))
        else begin
            fail_count++;
            $error("CSR state changed at an edge with stall or illegal high");
        end

    assert property (@(posedge clk) $rose(rst_n) |-> !illegal)
        else begin
            fail_count++;
            $error("illegal is high right after reset");
        end

    // MPP reads as 11 and only MPIE and MIE are live
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.valid && req.addr.raw == csr_mstatus)
            |-> (read_value[12:11] == 2'b11 && (read_value & ~32'h0000_1888) == 32'd0))
        else begin
            fail_count++;
            $error("mstatus read has wrong fixed bits: %h", read_value);
        end

endmodule

//--- verif/rv32_csr_unit_tb.sv
`timescale 1ns/1ps

module rv32_csr_unit_tb;
    import rv32_csr_addr_pkg::*;
    import rv32_csr_op_pkg::*;

    // About 2400 cycles of tests plus margin
    localparam int cycle_limit = 3000;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic        instr_retired;
    logic [31:0] read_value;
    logic        illegal;
    logic [31:0] lfsr;
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic [11:0] a;
    logic [31:0] word;
    logic [1:0]  sel;
    int          error_count;
    int          check_count;
    int          cycle_count;

    tb_clock_gen clock_i (.clk(clk));

    rv32_csr_unit rv32_csr_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rs1_value     (rs1_value),
        .instr_retired (instr_retired),
        .read_value    (read_value),
        .illegal       (illegal)
    );

    bind rv32_csr_file rv32_csr_unit_assert assert_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .illegal    (illegal),
        .req        (req),
        .read_value (read_value),
        .state      ({mstatus_mie, mstatus_mpie, mtvec_base, mtvec_mode, mscratch, mepc})
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'd0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_csr(input logic [11:0] addr, input logic [4:0] src,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {addr, src, f3, rd, opcode_system};
    endfunction

    function automatic logic [11:0] pick_reg();
        case (rand_bits(2))
            32'd0:   return csr_mstatus;
            32'd1:   return csr_mtvec;
            32'd2:   return csr_mscratch;
            default: return csr_mepc;
        endcase
    endfunction

    function automatic logic [11:0] pick_counter();
        case (rand_bits(4))
            32'd0:   return csr_cycleh;
            32'd1:   return csr_time;
            32'd2:   return csr_timeh;
            32'd3:   return csr_mcycle;
            32'd4:   return csr_mcycleh;
            32'd5:   return csr_instret;
            32'd6:   return csr_instreth;
            32'd7:   return csr_minstret;
            32'd8:   return csr_minstreth;
            default: return csr_cycle;
        endcase
    endfunction

    function automatic logic [2:0] pick_funct3();
        logic [2:0] f;
        f = 3'(rand_bits(3));
        if (f[1:0] == 2'b00)
            f[1:0] = 2'b11;
        return f;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            csr_mstatus:                          return m_mstatus | 32'h0000_1800;
            csr_misa:                             return misa_value;
            csr_mtvec:                            return m_mtvec;
            csr_mscratch:                         return m_mscratch;
            csr_mepc:                             return m_mepc;
            csr_cycle, csr_time, csr_mcycle:      return m_cycle[31:0];
            csr_cycleh, csr_timeh, csr_mcycleh:   return m_cycle[63:32];
            csr_instret, csr_minstret:            return m_instret[31:0];
            csr_instreth, csr_minstreth:          return m_instret[63:32];
            default:                              return 32'd0;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_op(input logic valid_in, input logic [31:0] w,
                          input logic [31:0] rs1_in, input logic stall_in);
        logic [11:0] addr;
        logic [2:0]  f3;
        logic        exp_valid;
        logic        exp_write;
        logic        exp_illegal;
        logic        known;
        logic [31:0] old;
        logic [31:0] operand;
        logic [31:0] next;
        @(posedge clk);
        #1;
        instr_valid   = valid_in;
        instr         = w;
        rs1_value     = rs1_in;
        stall         = stall_in;
        instr_retired = rand_bits(1) != 32'd0;
        @(negedge clk);
        addr      = w[31:20];
        f3        = w[14:12];
        exp_valid = valid_in && w[6:0] == 7'b1110011 && f3[1:0] != 2'b00;
        exp_write = f3[1:0] == 2'b01 || w[19:15] != 5'd0;
        operand   = f3[2] ? {27'd0, w[19:15]} : rs1_in;
        known     = addr inside {csr_mstatus, csr_misa, csr_mtvec, csr_mscratch, csr_mepc,
                                 csr_mcycle, csr_minstret, csr_mcycleh, csr_minstreth,
                                 csr_cycle, csr_time, csr_instret, csr_cycleh, csr_timeh,
                                 csr_instreth, [12'hF11:12'hF14], [12'h323:12'h33F],
                                 [12'h3A0:12'h3A3], [12'h3B0:12'h3BF], [12'hB03:12'hB1F],
                                 [12'hB83:12'hB9F]};
        exp_illegal = exp_valid && (!known || (exp_write && addr[11:10] == 2'b11));
        old         = (exp_valid && known) ? model_read(addr) : 32'd0;
        check_value(read_value, old, $sformatf("read_value of %h", addr));
        check_value({31'd0, illegal}, {31'd0, exp_illegal}, $sformatf("illegal of %h", addr));
        if (exp_valid && exp_write && !stall_in && !exp_illegal) begin
            case (f3[1:0])
                2'b01:   next = operand;
                2'b10:   next = old | operand;
                default: next = old & ~operand;
            endcase
            case (addr)
                csr_mstatus:  m_mstatus  = next & 32'h0000_0088;
                csr_mtvec:    m_mtvec    = next & 32'hFFFF_FFFD;
                csr_mscratch: m_mscratch = next;
                csr_mepc:     m_mepc     = next & 32'hFFFF_FFFC;
                default: ;
            endcase
        end
    endtask

    task automatic sweep_zero(input logic [11:0] first, input logic [11:0] last);
        logic [11:0] addr;
        addr = first;
        while (addr <= last) begin
            run_op(1'b1, make_csr(addr, 5'd0, funct3_csrrs, 5'd2), 32'd0, 1'b0);
            addr = addr + 12'd1;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            m_cycle <= m_cycle + 64'd1;
            if (instr_retired)
                m_instret <= m_instret + 64'd1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: tests still running after %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        lfsr          = 32'h85ad;
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        rst_n         = 1'b0;
        stall         = 1'b0;
        instr_valid   = 1'b0;
        instr         = 32'd0;
        rs1_value     = 32'd0;
        instr_retired = 1'b0;
        m_mstatus     = 32'd0;
        m_mtvec       = 32'd0;
        m_mscratch    = 32'd0;
        m_mepc        = 32'd0;
        m_cycle       = 64'd0;
        m_instret     = 64'd0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Random updates read back in the next cycle
        for (int n = 0; n < 600; n++) begin
            a = pick_reg();
            run_op(1'b1, make_csr(a, 5'(rand_bits(5)), pick_funct3(), 5'(rand_bits(5))),
                   rand_bits(32), 1'b0);
            run_op(1'b1, make_csr(a, 5'd0, funct3_csrrs, 5'd1), 32'd0, 1'b0);
        end
        // Set and clear with a zero source
        for (int n = 0; n < 150; n++) begin
            word = make_csr(pick_reg(), 5'd0, {rand_bits(1) != 32'd0, 1'b1, rand_bits(1) != 32'd0},
                            5'd4);
            run_op(1'b1, word, rand_bits(32), 1'b0);
        end
        for (int n = 0; n < 125; n++) begin
            a = pick_reg();
            run_op(1'b1, make_csr(a, 5'(rand_bits(5)), pick_funct3(), 5'd3), rand_bits(32), 1'b1);
            run_op(1'b1, make_csr(a, 5'd0, funct3_csrrs, 5'd3), 32'd0, rand_bits(1) != 32'd0);
        end
        for (int n = 0; n < 300; n++) begin
            run_op(1'b1, make_csr(pick_counter(), 5'd0, funct3_csrrs, 5'd5), 32'd0, 1'b0);
        end
        run_op(1'b1, make_csr(csr_misa, 5'd0, funct3_csrrs, 5'd6), 32'd0, 1'b0);
        sweep_zero(csr_mhpmevent_first, csr_mhpmevent_last);
        sweep_zero(csr_pmpcfg_first, csr_pmpcfg_last);
        sweep_zero(csr_pmpaddr_first, csr_pmpaddr_last);
        sweep_zero(csr_mhpmcounter_first, csr_mhpmcounter_last);
        sweep_zero(csr_mhpmcounterh_first, csr_mhpmcounterh_last);
        sweep_zero(csr_mvendorid, csr_mhartid);
        // Illegal accesses, foreign opcodes and idle cycles
        run_op(1'b1, make_csr(csr_mvendorid, 5'd3, funct3_csrrw, 5'd1), rand_bits(32), 1'b0);
        run_op(1'b1, make_csr(csr_cycle, 5'd5, funct3_csrrsi, 5'd1), 32'd0, 1'b0);
        for (int n = 0; n < 200; n++) begin
            word = rand_bits(32);
            sel  = 2'(rand_bits(2));
            case (sel)
                2'd1:    word = make_csr({2'b11, word[29:20]}, word[19:15], funct3_csrrw,
                                         word[11:7]);
                2'd2:    word[6:0] = 7'b0110011;
                default: word[6:0] = opcode_system;
            endcase
            run_op(sel != 2'd3, word, rand_bits(32), 1'b0);
        end

        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, rv32_csr_unit_i.file_i.assert_i.fail_count);
        if (error_count == 0 && rv32_csr_unit_i.file_i.assert_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rv32_csr.f
source/rv32_csr_addr_pkg.sv
source/rv32_csr_op_pkg.sv
source/rv32_csr_decode.sv
source/rv32_csr_counters.sv
source/rv32_csr_file.sv
source/rv32_csr_unit.sv
verif/tb_clock_gen.sv
verif/rv32_csr_unit_assert.sv
verif/rv32_csr_unit_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv32_csr_unit_tb
FILELIST = rv32_csr.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
